// File: hdl/kbd_consts.svh
`ifndef KBD_CONSTS_SVH
`define KBD_CONSTS_SVH

// event fifo depth
`define KBD_FIFO_DEPTH 8

// apb register offsets
`define KBD_REG_STATUS 4'h0
`define KBD_REG_DATA   4'h4
`define KBD_REG_CTRL   4'h8

// ctrl register bits
`define KBD_CTRL_RX_EN  0
`define KBD_CTRL_IRQ_EN 1

// status register bits, count field sits in bits 7..4
`define KBD_STAT_NEMPTY    0
`define KBD_STAT_OVF       1
`define KBD_STAT_COUNT_LSB 4

// set on a data read that returned an event
`define KBD_DATA_VALID 31

`endif

// File: hdl/common.sv
`default_nettype none

// keyboard data types shared by the receive path and the register block
package common;

    // one byte as it comes off the ps2 wire
    typedef logic [7:0] byte_t;

    // key event
    // bit 9 break, bit 8 extended, bits 7..0 scan code
    typedef logic [9:0] kbd_event_t;

    // fifo fill level, 0..8
    typedef logic [3:0] fifo_count_t;

endpackage

`default_nettype wire

// File: hdl/kbd_regs_pkg.sv
`default_nettype none

// types of the apb slave port
package kbd_regs_pkg;

    // byte address, only the low nibble is decoded
    typedef logic [3:0] apb_addr_t;

    // read and write data
    typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

// File: hdl/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx
    import common::*;
    (
        input  wire logic  clk_i,
        input  wire logic  reset_i,

        // raw ps2 lines from the keyboard
        input  wire logic  ps2_clk_async_i,
        input  wire logic  ps2_data_async_i,

        // received byte, valid for one cycle
        output      byte_t data_o,
        output      logic  valid_o
    );

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DATA   = 2'b01,
        PARITY = 2'b10,
        STOP   = 2'b11
    } rx_state_t;

    logic [1:0] ps2_clk_r;
    logic       ps2_data_r;
    logic       fall_w;

    rx_state_t  state_r;
    logic [2:0] bit_cnt_r;
    byte_t      shift_r;
    logic       parity_r;

    // lines idle high, so reset to 1 to avoid a false edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ps2_clk_r  <= 2'b11;
            ps2_data_r <= 1'b1;
        end else begin
            ps2_clk_r  <= {ps2_clk_r[0], ps2_clk_async_i};
            ps2_data_r <= ps2_data_async_i;
        end
    end

    // device changes data on rising clock, we sample on falling
    assign fall_w = ps2_clk_r[1] & ~ps2_clk_r[0];

    // frame fsm, advances once per ps2 clock fall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= IDLE;
            bit_cnt_r <= 3'd0;
            parity_r  <= 1'b0;
        end else if (fall_w) begin
            case (state_r)
                IDLE: begin
                    // low data bit here is the start bit
                    if (!ps2_data_r) begin
                        state_r   <= DATA;
                        bit_cnt_r <= 3'd0;
                        parity_r  <= 1'b0;
                    end
                end
                DATA: begin
                    parity_r  <= parity_r ^ ps2_data_r;
                    bit_cnt_r <= bit_cnt_r + 3'd1;
                    if (bit_cnt_r == 3'd7) begin
                        state_r <= PARITY;
                    end
                end
                PARITY: begin
                    // odd parity over data and parity bit
                    if (parity_r ^ ps2_data_r) begin
                        state_r <= STOP;
                    end else begin
                        state_r <= IDLE;
                    end
                end
                STOP: begin
                    state_r <= IDLE;
                end
                default: begin
                    state_r <= IDLE;
                end
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (fall_w && state_r == DATA) begin
            shift_r <= {ps2_data_r, shift_r[7:1]};
        end
    end

    // hand the byte on only with a good stop bit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= fall_w && state_r == STOP && ps2_data_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fall_w && state_r == STOP && ps2_data_r) begin
            data_o <= shift_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ps2_scancode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_scancode_decoder
    import common::*;
    (
        input  wire logic       clk_i,
        input  wire logic       reset_i,
        input  wire logic       rx_enable_i,

        // bytes from the frame receiver
        input  wire byte_t      data_i,
        input  wire logic       valid_i,

        // folded key events
        output      kbd_event_t event_o,
        output      logic       event_valid_o
    );

    localparam byte_t PREFIX_EXT = 8'hE0;
    localparam byte_t PREFIX_BRK = 8'hF0;

    logic ext_r;
    logic brk_r;
    logic code_w;

    // anything that is not a prefix closes the event
    assign code_w = valid_i && rx_enable_i &&
                    data_i != PREFIX_EXT && data_i != PREFIX_BRK;

    always_ff @(posedge clk_i) begin
        if (reset_i || !rx_enable_i) begin
            ext_r <= 1'b0;
            brk_r <= 1'b0;
        end else if (valid_i) begin
            if (data_i == PREFIX_EXT) begin
                ext_r <= 1'b1;
            end else if (data_i == PREFIX_BRK) begin
                brk_r <= 1'b1;
            end else begin
                ext_r <= 1'b0;
                brk_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= code_w;
        end
    end

    // event payload
    always_ff @(posedge clk_i) begin
        if (code_w) begin
            event_o <= {brk_r, ext_r, data_i};
        end
    end

endmodule

`default_nettype wire

// File: hdl/kbd_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_event_fifo
    import common::*;
    (
        input  wire logic        clk_i,
        input  wire logic        reset_i,

        // write side from the decoder
        input  wire logic        wr_i,
        input  wire kbd_event_t  wr_event_i,

        // read side, data shows before the pop
        input  wire logic        pop_i,
        output      kbd_event_t  rd_event_o,
        output      fifo_count_t count_o,
        output      logic        empty_o,
        output      logic        overflow_o
    );

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    kbd_event_t       mem_r [DEPTH];
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W-1:0] wr_ptr_r;
    fifo_count_t      count_r;

    logic full_w;
    logic do_pop_w;
    logic do_wr_w;

    assign full_w   = count_r == fifo_count_t'(DEPTH);
    assign empty_o  = count_r == '0;
    assign do_pop_w = pop_i && !empty_o;
    // a pop in the same cycle frees a slot when full
    assign do_wr_w  = wr_i && (!full_w || do_pop_w);

    assign overflow_o = wr_i && !do_wr_w;
    assign rd_event_o = mem_r[rd_ptr_r];
    assign count_o    = count_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_r <= '0;
            wr_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_pop_w) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            if (do_wr_w) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_wr_w && !do_pop_w) begin
                count_r <= count_r + 1'b1;
            end else if (do_pop_w && !do_wr_w) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr_w) begin
            mem_r[wr_ptr_r] <= wr_event_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/kbd_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_apb_regs
    import common::*;
    import kbd_regs_pkg::*;
    (
        input  wire logic        clk_i,
        input  wire logic        reset_i,

        // apb slave
        input  wire logic        psel_i,
        input  wire logic        penable_i,
        input  wire logic        pwrite_i,
        input  wire apb_addr_t   paddr_i,
        input  wire apb_data_t   pwdata_i,
        output      apb_data_t   prdata_o,
        output      logic        pready_o,
        output      logic        pslverr_o,

        // fifo status and head entry
        input  wire kbd_event_t  rd_event_i,
        input  wire fifo_count_t count_i,
        input  wire logic        empty_i,
        input  wire logic        overflow_i,

        output      logic        pop_o,
        output      logic        rx_enable_o,
        output      logic        irq_o
    );

    logic access_w;
    logic wr_w;
    logic rd_w;
    logic sel_status_w;
    logic sel_data_w;
    logic sel_ctrl_w;

    logic rx_en_r;
    logic irq_en_r;
    logic ovf_r;

    // every transfer ends in the access phase
    assign access_w = psel_i && penable_i;
    assign wr_w     = access_w && pwrite_i;
    assign rd_w     = access_w && !pwrite_i;

    assign sel_status_w = paddr_i == `KBD_REG_STATUS;
    assign sel_data_w   = paddr_i == `KBD_REG_DATA;
    assign sel_ctrl_w   = paddr_i == `KBD_REG_CTRL;

    assign pready_o  = 1'b1;
    assign pslverr_o = access_w && !(sel_status_w || sel_data_w || sel_ctrl_w);

    // reading DATA consumes the head event
    assign pop_o = rd_w && sel_data_w && !empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_en_r  <= 1'b0;
            irq_en_r <= 1'b0;
        end else if (wr_w && sel_ctrl_w) begin
            rx_en_r  <= pwdata_i[`KBD_CTRL_RX_EN];
            irq_en_r <= pwdata_i[`KBD_CTRL_IRQ_EN];
        end
    end

    // sticky overflow, a new drop wins over a clear
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ovf_r <= 1'b0;
        end else if (overflow_i) begin
            ovf_r <= 1'b1;
        end else if (wr_w && sel_status_w && pwdata_i[`KBD_STAT_OVF]) begin
            ovf_r <= 1'b0;
        end
    end

    // read mux
    always_comb begin
        prdata_o = '0;
        if (rd_w) begin
            if (sel_status_w) begin
                prdata_o[`KBD_STAT_NEMPTY] = !empty_i;
                prdata_o[`KBD_STAT_OVF]    = ovf_r;
                prdata_o[`KBD_STAT_COUNT_LSB +: $bits(fifo_count_t)] = count_i;
            end else if (sel_data_w) begin
                if (!empty_i) begin
                    prdata_o[$bits(kbd_event_t)-1:0] = rd_event_i;
                    prdata_o[`KBD_DATA_VALID]        = 1'b1;
                end
            end else if (sel_ctrl_w) begin
                prdata_o[`KBD_CTRL_RX_EN]  = rx_en_r;
                prdata_o[`KBD_CTRL_IRQ_EN] = irq_en_r;
            end
        end
    end

    assign rx_enable_o = rx_en_r;
    assign irq_o       = irq_en_r && !empty_i;

endmodule

`default_nettype wire

// File: hdl/kbd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_ctrl_top
    import common::*;
    import kbd_regs_pkg::*;
    (
        input  wire logic      clk_i,
        input  wire logic      reset_i,

        // ps2 keyboard lines
        input  wire logic      ps2_clk_async_i,
        input  wire logic      ps2_data_async_i,

        // apb slave
        input  wire logic      psel_i,
        input  wire logic      penable_i,
        input  wire logic      pwrite_i,
        input  wire apb_addr_t paddr_i,
        input  wire apb_data_t pwdata_i,
        output      apb_data_t prdata_o,
        output      logic      pready_o,
        output      logic      pslverr_o,

        output      logic      irq_o
    );

    byte_t       rx_byte_w;
    logic        rx_valid_w;
    kbd_event_t  event_w;
    logic        event_valid_w;
    kbd_event_t  rd_event_w;
    fifo_count_t count_w;
    logic        empty_w;
    logic        overflow_w;
    logic        pop_w;
    logic        rx_enable_w;

    ps2_rx i_ps2_rx (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ps2_clk_async_i  (ps2_clk_async_i),
        .ps2_data_async_i (ps2_data_async_i),
        .data_o           (rx_byte_w),
        .valid_o          (rx_valid_w)
    );

    ps2_scancode_decoder i_ps2_scancode_decoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rx_enable_i   (rx_enable_w),
        .data_i        (rx_byte_w),
        .valid_i       (rx_valid_w),
        .event_o       (event_w),
        .event_valid_o (event_valid_w)
    );

    kbd_event_fifo i_kbd_event_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_i       (event_valid_w),
        .wr_event_i (event_w),
        .pop_i      (pop_w),
        .rd_event_o (rd_event_w),
        .count_o    (count_w),
        .empty_o    (empty_w),
        .overflow_o (overflow_w)
    );

    kbd_apb_regs i_kbd_apb_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .rd_event_i  (rd_event_w),
        .count_i     (count_w),
        .empty_i     (empty_w),
        .overflow_i  (overflow_w),
        .pop_o       (pop_w),
        .rx_enable_o (rx_enable_w),
        .irq_o       (irq_o)
    );

endmodule

`default_nettype wire

// File: sim/kbd_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_checker
    import common::*;
    import kbd_regs_pkg::*;
    (
        input  wire logic      clk_i,
        input  wire logic      reset_i,

        // ps2 lines as driven by the device model
        input  wire logic      ps2_clk_i,
        input  wire logic      ps2_data_i,

        // apb bus, both directions
        input  wire logic      psel_i,
        input  wire logic      penable_i,
        input  wire logic      pwrite_i,
        input  wire apb_addr_t paddr_i,
        input  wire apb_data_t pwdata_i,
        input  wire apb_data_t prdata_i,
        input  wire logic      pready_i,
        input  wire logic      pslverr_i,
        input  wire logic      irq_i,

        output int             error_count_o,
        output int             check_count_o,
        output int             event_count_o
    );

    kbd_event_t  model_q[$];
    logic        rx_en;
    logic        irq_en;
    logic        ovf;
    logic        pend_ext;
    logic        pend_brk;
    logic        ps2_clk_d;
    logic [10:0] frame;
    int          bit_idx;

    task automatic flag_error(input string msg);
        error_count_o = error_count_o + 1;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // prefix folding and fifo model for one good byte
    task automatic take_byte(input byte_t b);
        if (!rx_en) begin
            pend_ext = 1'b0;
            pend_brk = 1'b0;
        end else if (b == 8'hE0) begin
            pend_ext = 1'b1;
        end else if (b == 8'hF0) begin
            pend_brk = 1'b1;
        end else begin
            if (model_q.size() < `KBD_FIFO_DEPTH) begin
                model_q.push_back({pend_brk, pend_ext, b});
            end else begin
                ovf = 1'b1;
            end
            pend_ext = 1'b0;
            pend_brk = 1'b0;
        end
    endtask

    // collect 11 bits on ps2 clock falls
    task automatic watch_line();
        if (ps2_clk_d && !ps2_clk_i) begin
            if (bit_idx != 0 || !ps2_data_i) begin
                frame[bit_idx] = ps2_data_i;
                bit_idx = bit_idx + 1;
            end
            if (bit_idx == 11) begin
                bit_idx = 0;
                // odd parity over data and parity, stop must be high
                if (^frame[9:1] && frame[10]) begin
                    take_byte(frame[8:1]);
                end
            end
        end
        ps2_clk_d = ps2_clk_i;
    endtask

    task automatic check_access();
        apb_data_t exp;
        logic      mapped;
        logic      exp_irq;
        string     name;
        mapped = paddr_i == `KBD_REG_STATUS || paddr_i == `KBD_REG_DATA ||
                 paddr_i == `KBD_REG_CTRL;
        exp_irq = irq_en && model_q.size() != 0;
        check_count_o = check_count_o + 1;
        if (pslverr_i !== !mapped) begin
            flag_error($sformatf("PSLVERR %b at offset 0x%0h, expected %b",
                                 pslverr_i, paddr_i, !mapped));
        end
        if (irq_i !== exp_irq) begin
            flag_error($sformatf("irq %b, expected %b", irq_i, exp_irq));
        end
        if (!pwrite_i) begin
            exp = '0;
            name = "unmapped";
            if (paddr_i == `KBD_REG_STATUS) begin
                name = "STATUS";
                exp[`KBD_STAT_NEMPTY] = model_q.size() != 0;
                exp[`KBD_STAT_OVF] = ovf;
                exp[`KBD_STAT_COUNT_LSB +: 4] = 4'(model_q.size());
            end else if (paddr_i == `KBD_REG_DATA) begin
                name = "DATA";
                if (model_q.size() != 0) begin
                    exp[9:0] = model_q[0];
                    exp[`KBD_DATA_VALID] = 1'b1;
                end
            end else if (paddr_i == `KBD_REG_CTRL) begin
                name = "CTRL";
                exp[`KBD_CTRL_RX_EN] = rx_en;
                exp[`KBD_CTRL_IRQ_EN] = irq_en;
            end
            if (prdata_i !== exp) begin
                flag_error($sformatf("%s read 0x%08h, expected 0x%08h", name, prdata_i, exp));
            end
            if (paddr_i == `KBD_REG_DATA && model_q.size() != 0) begin
                void'(model_q.pop_front());
                event_count_o = event_count_o + 1;
            end
        end else if (paddr_i == `KBD_REG_CTRL) begin
            rx_en = pwdata_i[`KBD_CTRL_RX_EN];
            irq_en = pwdata_i[`KBD_CTRL_IRQ_EN];
            // decoder drops pending prefixes while disabled
            if (!rx_en) begin
                pend_ext = 1'b0;
                pend_brk = 1'b0;
            end
        end else if (paddr_i == `KBD_REG_STATUS && pwdata_i[`KBD_STAT_OVF]) begin
            ovf = 1'b0;
        end
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            model_q.delete();
            rx_en = 1'b0;
            irq_en = 1'b0;
            ovf = 1'b0;
            pend_ext = 1'b0;
            pend_brk = 1'b0;
            ps2_clk_d = 1'b1;
            bit_idx = 0;
            error_count_o = 0;
            check_count_o = 0;
            event_count_o = 0;
        end else begin
            watch_line();
            if (psel_i && penable_i && pready_i) begin
                check_access();
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_kbd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module tb_kbd_ctrl_top
    import common::*;
    import kbd_regs_pkg::*;
    ();

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES = 16;
    localparam int KEYS_DISABLED = 4;
    localparam int KEYS_RANDOM = 40;
    localparam int KEYS_OVERFLOW = 11;
    localparam int KEYS_NO_IRQ = 2;
    // up to three frames per key, 22 half periods of at most 10 clocks plus slack
    localparam int MAX_FRAMES = 3 * (KEYS_DISABLED + KEYS_RANDOM + KEYS_OVERFLOW + KEYS_NO_IRQ);
    localparam int FRAME_MAX_CYCLES = 22 * 10 + 100;
    localparam longint TIMEOUT_NS = longint'(MAX_FRAMES) * FRAME_MAX_CYCLES * 2 * CLK_PERIOD_NS +
                                    RESET_CYCLES * CLK_PERIOD_NS;

    logic        clk = 1'b0;
    logic        reset;
    logic        ps2_clk;
    logic        ps2_data;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    int          error_count;
    int          check_count;
    int          event_count;
    int          bus_timeouts = 0;
    logic [31:0] rng_state = 32'h0093_7008;
    int          k;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    kbd_ctrl_top i_kbd_ctrl_top (
        .clk_i            (clk),
        .reset_i          (reset),
        .ps2_clk_async_i  (ps2_clk),
        .ps2_data_async_i (ps2_data),
        .psel_i           (psel),
        .penable_i        (penable),
        .pwrite_i         (pwrite),
        .paddr_i          (paddr),
        .pwdata_i         (pwdata),
        .prdata_o         (prdata),
        .pready_o         (pready),
        .pslverr_o        (pslverr),
        .irq_o            (irq)
    );

    kbd_checker i_kbd_checker (
        .clk_i         (clk),
        .reset_i       (reset),
        .ps2_clk_i     (ps2_clk),
        .ps2_data_i    (ps2_data),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_i      (prdata),
        .pready_i      (pready),
        .pslverr_i     (pslverr),
        .irq_i         (irq),
        .error_count_o (error_count),
        .check_count_o (check_count),
        .event_count_o (event_count)
    );

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // 0 clean, 1 parity flipped, 2 stop bit low
    function automatic int pick_error(input logic allow);
        logic [31:0] r;
        r = next_random();
        if (!allow || r[2:0] != 3'd0) begin
            return 0;
        end
        return 1 + int'(r[3]);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // device side, data changes while the clock is high
    task automatic send_frame(input byte_t b, input int err_kind);
        logic [10:0] bits;
        int          half;
        int          i;
        bits = {1'b1, ~^b, b, 1'b0};
        if (err_kind == 1) begin
            bits[9] = ~bits[9];
        end else if (err_kind == 2) begin
            bits[10] = 1'b0;
        end
        half = 4 + int'(next_random() % 7);
        @(posedge clk);
        for (i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            wait_cycles(half);
            ps2_clk <= 1'b0;
            wait_cycles(half);
            ps2_clk <= 1'b1;
        end
        wait_cycles(half);
        ps2_data <= 1'b1;
    endtask

    task automatic send_key(input logic allow_err);
        logic [31:0] r;
        byte_t       code;
        r = next_random();
        code = r[7:0];
        if (code == 8'hE0 || code == 8'hF0) begin
            code = code ^ 8'h01;
        end
        if (r[8]) begin
            send_frame(8'hE0, pick_error(allow_err));
        end
        if (r[9]) begin
            send_frame(8'hF0, pick_error(allow_err));
        end
        send_frame(code, pick_error(allow_err));
        // let the event reach the fifo before any bus access
        wait_cycles(12 + int'(next_random() % 20));
    endtask

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
        int waits;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(posedge clk);
        while (!pready && waits < 16) begin
            waits++;
            @(posedge clk);
        end
        if (!pready) begin
            bus_timeouts++;
            $display("APB transfer to offset 0x%0h never saw PREADY", addr);
        end
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr);
        apb_xfer(1'b0, addr, '0);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_xfer(1'b1, addr, wdata);
    endtask

    task automatic drain_data(input int n);
        repeat (n) apb_read(`KBD_REG_DATA);
    endtask

    initial begin
        reset <= 1'b1;
        ps2_clk <= 1'b1;
        ps2_data <= 1'b1;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        wait_cycles(RESET_CYCLES);
        reset <= 1'b0;
        wait_cycles(4);

        // receive still disabled
        for (k = 0; k < KEYS_DISABLED; k++) begin
            send_key(1'b1);
        end
        apb_read(`KBD_REG_STATUS);
        apb_read(`KBD_REG_DATA);
        apb_read(`KBD_REG_CTRL);

        apb_write(`KBD_REG_CTRL, (1 << `KBD_CTRL_RX_EN) | (1 << `KBD_CTRL_IRQ_EN));
        for (k = 0; k < KEYS_RANDOM; k++) begin
            send_key(1'b1);
            if (next_random() % 4 != 0) begin
                apb_read(`KBD_REG_STATUS);
                apb_read(`KBD_REG_DATA);
            end
            if (k % 6 == 5) begin
                drain_data(8);
            end
        end
        drain_data(8);

        // fill past the depth with no reads
        for (k = 0; k < KEYS_OVERFLOW; k++) begin
            send_key(1'b0);
        end
        apb_read(`KBD_REG_STATUS);
        apb_read(4'hC);
        apb_write(4'h6, 32'hFFFF_FFFF);
        apb_read(`KBD_REG_CTRL);
        apb_read(`KBD_REG_STATUS);
        apb_write(`KBD_REG_STATUS, 1 << `KBD_STAT_OVF);
        apb_read(`KBD_REG_STATUS);
        drain_data(9);
        apb_read(`KBD_REG_STATUS);

        // interrupt masked
        apb_write(`KBD_REG_CTRL, 1 << `KBD_CTRL_RX_EN);
        for (k = 0; k < KEYS_NO_IRQ; k++) begin
            send_key(1'b0);
        end
        apb_read(`KBD_REG_STATUS);
        drain_data(3);
        wait_cycles(4);

        $display("checks %0d, events read %0d, checker errors %0d, bus timeouts %0d",
                 check_count, event_count, error_count, bus_timeouts);
        if (event_count == 0) begin
            $display("no key events came back through the DATA register");
        end
        if (error_count == 0 && bus_timeouts == 0 && event_count > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the test sequence ended", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/common.sv
hdl/kbd_regs_pkg.sv
hdl/ps2_rx.sv
hdl/ps2_scancode_decoder.sv
hdl/kbd_event_fifo.sv
hdl/kbd_apb_regs.sv
hdl/kbd_ctrl_top.sv
sim/kbd_checker.sv
sim/tb_kbd_ctrl_top.sv

// File: run.sh
#!/bin/sh
# build and run the keyboard controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_kbd_ctrl_top -f filelist.f -Mdir obj_dir -o sim_kbd
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_kbd)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
